// ==== common/rf_geom_pkg.sv ====
//--------------------------------------
// Geometry of the power-gated register file
// Word width, bank depth, bank count and the
// address widths derived from them
//--------------------------------------

package rf_geom_pkg;

    //--------------------------------------
    // Word and bank sizes
    //--------------------------------------

    // Width of one stored word
    localparam int unsigned DATA_W = 100;

    // Entries held by one bank
    localparam int unsigned BANK_DEPTH = 4;

    // Banks working side by side
    localparam int unsigned NUM_BANKS = 2;

    //--------------------------------------
    // Address widths
    //--------------------------------------

    // Bank-local address, the low bits of the full address
    localparam int unsigned BANK_ADDR_W = $clog2(BANK_DEPTH);

    // Full address, the top bit picks the bank
    localparam int unsigned ADDR_W = BANK_ADDR_W + $clog2(NUM_BANKS);

endpackage

// ==== common/rf_pwr_pkg.sv ====
//--------------------------------------
// Power-gate definitions
// State encoding of the bank controller and
// the length of the wake sequence
//--------------------------------------

package rf_pwr_pkg;

    //--------------------------------------
    // Controller state
    //--------------------------------------

    // Width of the encoded state
    localparam int unsigned PG_STATE_W = 2;

    // PG_ON is the only state where the bank may be accessed
    typedef enum logic [PG_STATE_W-1:0] {
        PG_ON      = 2'b00,
        PG_ISOLATE = 2'b01,
        PG_OFF     = 2'b10,
        PG_WAKE    = 2'b11
    } pg_state_e;

    //--------------------------------------
    // Sequencing
    //--------------------------------------

    // Cycles spent in PG_WAKE before the bank is usable again
    localparam int unsigned PG_WAKE_CYCLES = 4;

    // Counter width that covers the wake cycles
    localparam int unsigned PG_WAKE_CNT_W = $clog2(PG_WAKE_CYCLES);

endpackage

// ==== flist.f ====
common/rf_geom_pkg.sv
common/rf_pwr_pkg.sv
rtl/rf_bank/rf_array.sv
rtl/rf_bank/rf_pg_ctrl.sv
rtl/rf_bank/rf_pg_bank.sv
rtl/rf_read_merge.sv
rtl/rf_pg_8x100.sv
verification/rf_pg_tb.sv

// ==== rtl/rf_bank/rf_array.sv ====
//--------------------------------------
// Storage array of one bank
// Synchronous write, registered read and
// clear of all entries on power down
//--------------------------------------

`timescale 1ns/1ps

module rf_array (
     input  logic                                clk
    ,input  logic                                rst

    ,input  logic                                we
    ,input  logic [rf_geom_pkg::BANK_ADDR_W-1:0] waddr
    ,input  logic [rf_geom_pkg::DATA_W-1:0]      wdata

    ,input  logic                                re
    ,input  logic [rf_geom_pkg::BANK_ADDR_W-1:0] raddr

    ,input  logic                                clear

    ,output logic [rf_geom_pkg::DATA_W-1:0]      rdata
);

    // One word per bank entry
    logic [rf_geom_pkg::DATA_W-1:0] mem [rf_geom_pkg::BANK_DEPTH];

    //--------------------------------------
    // Write side
    //--------------------------------------

    // Reset and the power-down clear both wipe the whole array
    // A write lands on the same edge that samples we, so a read
    // strobed in the next cycle already sees the new word
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int i = 0; i < rf_geom_pkg::BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //--------------------------------------
    // Read side
    //--------------------------------------

    // Output register holds the last word read until the next strobe
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    //--------------------------------------
    // Checks
    //--------------------------------------

    // The controller only clears while the bank is off, and the bank
    // blocks writes in every state but PG_ON, so both never meet here
    a_no_write_during_clear : assert property (
        @(posedge clk) disable iff (rst)
        !(we && clear)
    );

endmodule

// ==== rtl/rf_bank/rf_pg_bank.sv ====
//--------------------------------------
// One power-gated bank
// Controller plus array, with access gated
// by power state and isolated read data
//--------------------------------------

`timescale 1ns/1ps

module rf_pg_bank (
     input  logic                                clk
    ,input  logic                                rst

    ,input  logic                                we
    ,input  logic [rf_geom_pkg::BANK_ADDR_W-1:0] waddr
    ,input  logic [rf_geom_pkg::DATA_W-1:0]      wdata

    ,input  logic                                re
    ,input  logic [rf_geom_pkg::BANK_ADDR_W-1:0] raddr
    ,output logic [rf_geom_pkg::DATA_W-1:0]      rdata
    ,output logic                                rd_ok

    // Power chain
    ,input  logic                                pwr_enable_b_in
    ,output logic                                pwr_enable_b_out
);

    logic                           isol;
    logic                           clear;
    logic                           pg_on;
    logic                           arr_we;
    logic                           arr_re;
    logic [rf_geom_pkg::DATA_W-1:0] arr_rdata;

    // Isolation as it stood when the current read result was captured
    logic                           rd_isol;

    //--------------------------------------
    // Power-gate controller
    //--------------------------------------

    rf_pg_ctrl u_pg_ctrl (
         .clk              (clk)
        ,.rst              (rst)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.isol             (isol)
        ,.clear            (clear)
        ,.pg_on            (pg_on)
    );

    //--------------------------------------
    // Access gating
    //--------------------------------------

    // Writes to a bank that is not fully on are dropped,
    // reads are refused and reported through rd_ok
    assign arr_we = we && pg_on;
    assign arr_re = re && pg_on;

    rf_array u_array (
         .clk   (clk)
        ,.rst   (rst)
        ,.we    (arr_we)
        ,.waddr (waddr)
        ,.wdata (wdata)
        ,.re    (arr_re)
        ,.raddr (raddr)
        ,.clear (clear)
        ,.rdata (arr_rdata)
    );

    // Both flags line up with the registered array output
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ok   <= 1'b0;
            rd_isol <= 1'b0;
        end else begin
            rd_ok   <= arr_re;
            rd_isol <= isol;
        end
    end

    //--------------------------------------
    // Output isolation
    //--------------------------------------

    // Clamp to zero while the data comes from a bank that was not on
    assign rdata = rd_isol ? '0 : arr_rdata;

    //--------------------------------------
    // Checks
    //--------------------------------------

    // The array is never written while the controller isolates it
    a_no_write_isolated : assert property (
        @(posedge clk) disable iff (rst)
        arr_we |-> !isol
    );

endmodule

// ==== rtl/rf_bank/rf_pg_ctrl.sv ====
//--------------------------------------
// Power-gate controller of one bank
// ON, ISOLATE, OFF and WAKE sequencing with
// isolation, array clear and chained enable
//--------------------------------------

`timescale 1ns/1ps

module rf_pg_ctrl (
     input  logic clk
    ,input  logic rst

    // Active-low power request in, and the same request passed on
    ,input  logic pwr_enable_b_in
    ,output logic pwr_enable_b_out

    ,output logic isol
    ,output logic clear
    ,output logic pg_on
);

    rf_pwr_pkg::pg_state_e state;
    rf_pwr_pkg::pg_state_e state_nxt;

    // Counts the cycles already spent in PG_WAKE
    logic [rf_pwr_pkg::PG_WAKE_CNT_W-1:0] wake_cnt;

    //--------------------------------------
    // Next state
    //--------------------------------------

    // A request is only looked at in PG_ON and PG_OFF, so a request
    // that flips during ISOLATE or WAKE waits until the sequence ends
    always_comb begin
        state_nxt = state;
        case (state)
            rf_pwr_pkg::PG_ON: begin
                if (pwr_enable_b_in) begin
                    state_nxt = rf_pwr_pkg::PG_ISOLATE;
                end
            end
            rf_pwr_pkg::PG_ISOLATE: begin
                // Outputs are clamped for one cycle before the bank drops
                state_nxt = rf_pwr_pkg::PG_OFF;
            end
            rf_pwr_pkg::PG_OFF: begin
                if (!pwr_enable_b_in) begin
                    state_nxt = rf_pwr_pkg::PG_WAKE;
                end
            end
            rf_pwr_pkg::PG_WAKE: begin
                if (wake_cnt == rf_pwr_pkg::PG_WAKE_CNT_W'(rf_pwr_pkg::PG_WAKE_CYCLES - 1)) begin
                    state_nxt = rf_pwr_pkg::PG_ON;
                end
            end
            default: begin
                state_nxt = rf_pwr_pkg::PG_ON;
            end
        endcase
    end

    //--------------------------------------
    // State, wake counter and clear pulse
    //--------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rf_pwr_pkg::PG_ON;
            wake_cnt <= '0;
            clear    <= 1'b0;
        end else begin
            state <= state_nxt;
            // Counter rests at zero outside of the wake sequence
            if (state == rf_pwr_pkg::PG_WAKE) begin
                wake_cnt <= wake_cnt + 1'b1;
            end else begin
                wake_cnt <= '0;
            end
            // ISOLATE always leads to OFF, so this marks the first OFF cycle
            clear <= (state == rf_pwr_pkg::PG_ISOLATE);
        end
    end

    //--------------------------------------
    // Outputs
    //--------------------------------------

    assign pg_on = (state == rf_pwr_pkg::PG_ON);

    // The next bank in the chain may only wake once this one is fully on
    assign pwr_enable_b_out = !pg_on;
    assign isol             = !pg_on;

    //--------------------------------------
    // Checks
    //--------------------------------------

    // Power never drops without the isolation cycle in front of it
    a_off_from_isolate : assert property (
        @(posedge clk) disable iff (rst)
        $rose(state == rf_pwr_pkg::PG_OFF) |-> $past(state) == rf_pwr_pkg::PG_ISOLATE
    );

    // PG_ON is entered only from PG_WAKE
    a_on_from_wake : assert property (
        @(posedge clk) disable iff (rst)
        $rose(state == rf_pwr_pkg::PG_ON) |-> $past(state) == rf_pwr_pkg::PG_WAKE
    );

    // Wake lasts exactly the sequencing length and then ends in PG_ON
    a_wake_length : assert property (
        @(posedge clk) disable iff (rst)
        $rose(state == rf_pwr_pkg::PG_WAKE) |->
            (state == rf_pwr_pkg::PG_WAKE) [*rf_pwr_pkg::PG_WAKE_CYCLES]
            ##1 (state == rf_pwr_pkg::PG_ON)
    );

    // The array sees a single-cycle clear per power down
    a_clear_pulse : assert property (
        @(posedge clk) disable iff (rst)
        clear |=> !clear
    );

endmodule

// ==== rtl/rf_pg_8x100.sv ====
//--------------------------------------
// Power-gated 8x100 register file
// Two 4-entry banks on one power chain
// and a merged read port
//--------------------------------------

`timescale 1ns/1ps

module rf_pg_8x100 (
     input  logic                           clk
    ,input  logic                           rst

    ,input  logic                           we
    ,input  logic [rf_geom_pkg::ADDR_W-1:0] waddr
    ,input  logic [rf_geom_pkg::DATA_W-1:0] wdata

    ,input  logic                           re
    ,input  logic [rf_geom_pkg::ADDR_W-1:0] raddr
    ,output logic                           rvalid
    ,output logic                           rerr
    ,output logic [rf_geom_pkg::DATA_W-1:0] rdata

    // Power chain, active low
    ,input  logic                           pwr_enable_b
    ,output logic                           pwr_enable_b_out
);

    logic                              wsel;
    logic                              rsel;
    logic [rf_geom_pkg::DATA_W-1:0]    bank_rdata [rf_geom_pkg::NUM_BANKS];
    logic [rf_geom_pkg::NUM_BANKS-1:0] bank_rd_ok;

    // Link i feeds bank i, the last link leaves the chip
    logic [rf_geom_pkg::NUM_BANKS:0]   pwr_chain;

    //--------------------------------------
    // Address decode
    //--------------------------------------

    // Top address bit picks the bank
    assign wsel = waddr[rf_geom_pkg::ADDR_W-1];
    assign rsel = raddr[rf_geom_pkg::ADDR_W-1];

    assign pwr_chain[0]     = pwr_enable_b;
    assign pwr_enable_b_out = pwr_chain[rf_geom_pkg::NUM_BANKS];

    //--------------------------------------
    // Banks
    //--------------------------------------

    for (genvar g = 0; g < rf_geom_pkg::NUM_BANKS; g++) begin : g_bank
        logic bank_we;
        logic bank_re;

        // Only the addressed bank sees the strobe, both see the low bits
        assign bank_we = we && (wsel == 1'(g));
        assign bank_re = re && (rsel == 1'(g));

        rf_pg_bank u_bank (
             .clk              (clk)
            ,.rst              (rst)
            ,.we               (bank_we)
            ,.waddr            (waddr[rf_geom_pkg::BANK_ADDR_W-1:0])
            ,.wdata            (wdata)
            ,.re               (bank_re)
            ,.raddr            (raddr[rf_geom_pkg::BANK_ADDR_W-1:0])
            ,.rdata            (bank_rdata[g])
            ,.rd_ok            (bank_rd_ok[g])
            ,.pwr_enable_b_in  (pwr_chain[g])
            ,.pwr_enable_b_out (pwr_chain[g+1])
        );
    end

    //--------------------------------------
    // Read merge
    //--------------------------------------

    rf_read_merge u_read_merge (
         .clk         (clk)
        ,.rst         (rst)
        ,.re          (re)
        ,.rbank       (rsel)
        ,.bank0_rdata (bank_rdata[0])
        ,.bank1_rdata (bank_rdata[1])
        ,.bank0_rd_ok (bank_rd_ok[0])
        ,.bank1_rd_ok (bank_rd_ok[1])
        ,.rvalid      (rvalid)
        ,.rerr        (rerr)
        ,.rdata       (rdata)
    );

endmodule

// ==== rtl/rf_read_merge.sv ====
//--------------------------------------
// Read merge of the two banks
// One read port with valid and error strobes
//--------------------------------------

`timescale 1ns/1ps

module rf_read_merge (
     input  logic                           clk
    ,input  logic                           rst

    // Read request as seen at the top level
    ,input  logic                           re
    ,input  logic                           rbank

    // Registered results of both banks
    ,input  logic [rf_geom_pkg::DATA_W-1:0] bank0_rdata
    ,input  logic [rf_geom_pkg::DATA_W-1:0] bank1_rdata
    ,input  logic                           bank0_rd_ok
    ,input  logic                           bank1_rd_ok

    ,output logic                           rvalid
    ,output logic                           rerr
    ,output logic [rf_geom_pkg::DATA_W-1:0] rdata
);

    logic                           rvalid_q;
    logic                           rbank_q;
    logic                           sel_ok;
    logic [rf_geom_pkg::DATA_W-1:0] sel_data;

    // Request side is delayed to meet the banks' one-cycle read
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            rbank_q  <= 1'b0;
        end else begin
            rvalid_q <= re;
            rbank_q  <= rbank;
        end
    end

    //--------------------------------------
    // Result selection
    //--------------------------------------

    assign sel_ok   = rbank_q ? bank1_rd_ok : bank0_rd_ok;
    assign sel_data = rbank_q ? bank1_rdata : bank0_rdata;

    assign rvalid = rvalid_q;

    // A refused read comes back as an error with a zero word
    assign rerr  = rvalid_q && !sel_ok;
    assign rdata = (rvalid_q && sel_ok) ? sel_data : '0;

    //--------------------------------------
    // Checks
    //--------------------------------------

    // Every error belongs to a read that was strobed the cycle before
    a_err_has_read : assert property (
        @(posedge clk) disable iff (rst)
        rerr |-> rvalid && $past(re)
    );

endmodule

// ==== verification/rf_pg_tb.sv ====
//--------------------------------------
// Testbench of the power-gated 8x100 register file
// Clock, reset, stimulus, reference model and
// concurrent checks on the read and power ports
//--------------------------------------

`timescale 1ns/1ps

module rf_pg_tb;

    localparam int unsigned DATA_W     = rf_geom_pkg::DATA_W;
    localparam int unsigned ADDR_W     = rf_geom_pkg::ADDR_W;
    localparam int unsigned ENTRIES    = rf_geom_pkg::BANK_DEPTH * rf_geom_pkg::NUM_BANKS;
    localparam int unsigned CLK_PERIOD = 20;

    // Wake of the whole chain must finish within this many cycles
    localparam int unsigned WAKE_LIMIT = 2 * (rf_pwr_pkg::PG_WAKE_CYCLES + 2);

    // Watchdog budget, phases times the longest phase
    localparam int unsigned NUM_PHASES   = 5;
    localparam int unsigned PHASE_CYCLES = 400;

    logic              clk;
    logic              rst;
    logic              we;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
    logic              re;
    logic [ADDR_W-1:0] raddr;
    logic              rvalid;
    logic              rerr;
    logic [DATA_W-1:0] rdata;
    logic              pwr_enable_b;
    logic              pwr_enable_b_out;

    // Reference model state
    logic [DATA_W-1:0] model_mem [ENTRIES];
    logic [1:0]        bank_on;
    logic              exp_valid;
    logic              exp_rerr;
    logic [DATA_W-1:0] exp_rdata;

    rf_pg_8x100 dut (
         .clk              (clk)
        ,.rst              (rst)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rvalid           (rvalid)
        ,.rerr             (rerr)
        ,.rdata            (rdata)
        ,.pwr_enable_b     (pwr_enable_b)
        ,.pwr_enable_b_out (pwr_enable_b_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //--------------------------------------
    // Failure reporting
    //--------------------------------------

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        $display("Regression failed");
        $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
        $fatal(1, "value check failed");
    endtask

    task automatic report_failure(input string what);
        $display("Regression failed");
        $display("%s", what);
        $fatal(1, "check failed");
    endtask

    //--------------------------------------
    // Reference model
    //--------------------------------------

    // Bank 0 leaves PG_ON on the edge that samples the request high,
    // bank 1 one edge later, and both count as on again once the top
    // enable is seen low with the request low
    always @(posedge clk) begin
        if (rst) begin
            bank_on   <= 2'b11;
            exp_valid <= 1'b0;
            exp_rerr  <= 1'b0;
            exp_rdata <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                model_mem[i] <= '0;
            end
        end else begin
            // The read sees the array before a write on the same edge
            exp_valid <= re;
            exp_rerr  <= re && !bank_on[raddr[ADDR_W-1]];
            exp_rdata <= (re && bank_on[raddr[ADDR_W-1]]) ? model_mem[raddr] : '0;
            if (we && bank_on[waddr[ADDR_W-1]]) begin
                model_mem[waddr] <= wdata;
            end
            if (!pwr_enable_b && !pwr_enable_b_out) begin
                bank_on <= 2'b11;
            end else if (pwr_enable_b) begin
                // Power down wipes the bank, so the model clears it here
                if (bank_on[0]) begin
                    bank_on[0] <= 1'b0;
                    for (int i = 0; i < ENTRIES / 2; i++) begin
                        model_mem[i] <= '0;
                    end
                end else if (bank_on[1]) begin
                    bank_on[1] <= 1'b0;
                    for (int i = ENTRIES / 2; i < ENTRIES; i++) begin
                        model_mem[i] <= '0;
                    end
                end
            end
        end
    end

    //--------------------------------------
    // Concurrent checks
    //--------------------------------------

    a_reset_state : assert property (@(posedge clk)
        $fell(rst) |-> !pwr_enable_b_out && !rvalid && !rerr)
    else report_failure("outputs were not idle right after reset");

    // One rvalid per read strobe, exactly one cycle later
    a_rvalid : assert property (@(posedge clk) disable iff (rst)
        rvalid == exp_valid)
    else report_mismatch("rvalid", $sampled(exp_valid), $sampled(rvalid));

    a_rerr : assert property (@(posedge clk) disable iff (rst)
        rerr == exp_rerr)
    else report_mismatch("rerr", $sampled(exp_rerr), $sampled(rerr));

    a_rdata : assert property (@(posedge clk) disable iff (rst)
        rvalid |-> rdata == exp_rdata)
    else report_mismatch("rdata", $sampled(exp_rdata), $sampled(rdata));

    a_power_down : assert property (@(posedge clk) disable iff (rst)
        $rose(pwr_enable_b) |-> ##[1:2] pwr_enable_b_out)
    else report_failure("pwr_enable_b_out did not rise after the power-down request");

    a_wake_up : assert property (@(posedge clk) disable iff (rst)
        $fell(pwr_enable_b) |-> ##[1:WAKE_LIMIT] !pwr_enable_b_out)
    else report_failure("pwr_enable_b_out did not fall within the wake limit");

    //--------------------------------------
    // Stimulus tasks
    //--------------------------------------

    function automatic logic [DATA_W-1:0] random_word();
        logic [127:0] raw;
        raw = {$urandom(), $urandom(), $urandom(), $urandom()};
        return raw[DATA_W-1:0];
    endfunction

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        we    = 1'b1;
        waddr = addr;
        wdata = data;
        re    = 1'b0;
    endtask

    task automatic read_word(input logic [ADDR_W-1:0] addr);
        @(negedge clk);
        we    = 1'b0;
        re    = 1'b1;
        raddr = addr;
    endtask

    task automatic idle(input int unsigned cycles);
        repeat (cycles) begin
            @(negedge clk);
            we = 1'b0;
            re = 1'b0;
        end
    endtask

    // Back-to-back reads across the whole file
    task automatic read_all();
        for (int a = 0; a < ENTRIES; a++) begin
            read_word(ADDR_W'(a));
        end
        idle(2);
    endtask

    task automatic wait_pwr_out(input logic level, input int unsigned max_cycles);
        int unsigned n;
        n = 0;
        while (pwr_enable_b_out !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (pwr_enable_b_out !== level) begin
            report_failure("pwr_enable_b_out never reached the requested level");
        end
    endtask

    //--------------------------------------
    // Watchdog
    //--------------------------------------

    initial begin
        #(NUM_PHASES * PHASE_CYCLES * CLK_PERIOD);
        $display("Regression failed");
        $display("timeout: the test phases did not finish in time");
        $fatal(1, "watchdog expired");
    end

    //--------------------------------------
    // Test phases
    //--------------------------------------

    initial begin
        logic [ADDR_W-1:0] addr;
        void'($urandom(32'hf1ea4326));
        rst          = 1'b1;
        we           = 1'b0;
        waddr        = '0;
        wdata        = '0;
        re           = 1'b0;
        raddr        = '0;
        pwr_enable_b = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Phase 1, everything reads zero after reset
        idle(2);
        read_all();

        // Phase 2, random writes each followed at once by a read back
        for (int i = 0; i < 40; i++) begin
            addr = ADDR_W'($urandom_range(ENTRIES - 1, 0));
            write_word(addr, random_word());
            read_word(addr);
        end
        read_all();

        // Phase 3, same low address bits in both banks stay apart
        for (int a = 0; a < ENTRIES / 2; a++) begin
            write_word(ADDR_W'(a), random_word());
            read_word(ADDR_W'(a + ENTRIES / 2));
            write_word(ADDR_W'(a + ENTRIES / 2), random_word());
            read_word(ADDR_W'(a));
        end
        read_all();

        // Phase 4, power down, then reads fail and writes are dropped
        @(negedge clk);
        pwr_enable_b = 1'b1;
        wait_pwr_out(1'b1, WAKE_LIMIT);
        idle(4);
        read_all();
        for (int a = 0; a < ENTRIES; a++) begin
            write_word(ADDR_W'(a), random_word());
        end
        idle(1);
        read_all();

        // Phase 5, wake the chain and find the contents cleared
        @(negedge clk);
        pwr_enable_b = 1'b0;
        wait_pwr_out(1'b0, WAKE_LIMIT + 2);
        idle(2);
        read_all();
        idle(3);

        $display("Regression passed");
        $finish;
    end

endmodule
